//--- flist.f
bridge_regs_pkg.sv
fifo_pkg.sv
reg_if.sv
reg_access_decode.sv
byte_fifo.sv
reg_bank.sv
readback_irq.sv
bridge_regs_top.sv
tb_bridge_regs.sv

//--- run.sh
#!/bin/sh
# build and run the bridge register testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bridge_regs -f flist.f -o sim_bridge_regs

./obj_dir/sim_bridge_regs | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

//--- tb_bridge_regs.sv
// testbench for the apb to i2c register bridge, directed self-checking tests
`timescale 1ns/1ps
`default_nettype none

module tb_bridge_regs;
  import bridge_regs_pkg::*;
  import fifo_pkg::*;

  logic      rst;  // clock, named after the dut port
  logic      clk;  // async reset, active high
  apb_addr_t apb_waddr;
  apb_data_t apb_wdata;
  logic      apb_wr_en;
  apb_addr_t apb_raddr;
  apb_data_t apb_rdata;
  logic      apb_rd_done;
  reg_idx_t  i2c_addr;
  reg_byte_t i2c_wdata;
  logic      i2c_wr_en;
  reg_byte_t i2c_rdata;
  logic      i2c_rd_done;
  dev_addr_t dev_addr;
  logic      enable;
  reg_byte_t debounce;
  reg_byte_t scl_dly;
  reg_byte_t sda_dly;
  logic      i2c_irq;
  logic      apb_irq;
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;

  bridge_regs_top i_bridge_regs_top (
    .rst_i(rst), .clk_i(clk),
    .apb_waddr_i(apb_waddr), .apb_wdata_i(apb_wdata), .apb_wr_en_i(apb_wr_en),
    .apb_raddr_i(apb_raddr), .apb_rdata_o(apb_rdata), .apb_rd_done_i(apb_rd_done),
    .i2c_reg_addr_i(i2c_addr), .i2c_reg_wdata_i(i2c_wdata), .i2c_reg_wr_en_i(i2c_wr_en),
    .i2c_reg_rdata_o(i2c_rdata), .i2c_rd_done_i(i2c_rd_done),
    .i2c_dev_addr_o(dev_addr), .i2c_enable_o(enable), .i2c_debounce_o(debounce),
    .i2c_scl_dly_o(scl_dly), .i2c_sda_dly_o(sda_dly),
    .i2c_irq_o(i2c_irq), .apb_irq_o(apb_irq)
  );

  initial begin
    rst = 1'b0;
    forever #4 rst = ~rst;  // 8 ns period
  end

  // apb byte address of a register index
  function automatic apb_addr_t reg_addr(input reg_idx_t idx);
    return {2'b00, idx, 2'b00};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("test %-16s %s", name, (errors == errors_before) ? "ok" : "failed");
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge rst);
    apb_waddr <= addr;
    apb_wdata <= data;
    apb_wr_en <= 1'b1;
    @(posedge rst);
    apb_wr_en <= 1'b0;
  endtask

  task automatic i2c_write(input reg_idx_t idx, input reg_byte_t data);
    @(posedge rst);
    i2c_addr  <= idx;
    i2c_wdata <= data;
    i2c_wr_en <= 1'b1;
    @(posedge rst);
    i2c_wr_en <= 1'b0;
  endtask

  // read data is registered, valid one clock after the address
  task automatic apb_read(input apb_addr_t addr, input logic done, output apb_data_t data);
    @(posedge rst);
    apb_raddr <= addr;
    @(posedge rst);
    @(negedge rst);
    data = apb_rdata;
    if (done) begin
      @(posedge rst);
      apb_rd_done <= 1'b1;
      @(posedge rst);
      apb_rd_done <= 1'b0;
    end
  endtask

  task automatic i2c_read(input reg_idx_t idx, input logic done, output reg_byte_t data);
    @(posedge rst);
    i2c_addr <= idx;
    @(posedge rst);
    @(negedge rst);
    data = i2c_rdata;
    if (done) begin
      @(posedge rst);
      i2c_rd_done <= 1'b1;
      @(posedge rst);
      i2c_rd_done <= 1'b0;
    end
  endtask

  task automatic apb_expect(input string name, input apb_addr_t addr, input logic done,
                            input apb_data_t exp);
    apb_data_t d;
    apb_read(addr, done, d);
    check_eq(name, exp, d);
  endtask

  task automatic i2c_expect(input string name, input reg_idx_t idx, input logic done,
                            input reg_byte_t exp);
    reg_byte_t d;
    i2c_read(idx, done, d);
    check_eq(name, exp, d);
  endtask

  task automatic wait_irq(input string name, input logic apb_side, input logic level);
    int n;
    n = 0;
    while (((apb_side ? apb_irq : i2c_irq) !== level) && n < 20) begin
      @(negedge rst);
      n++;
    end
    checks++;
    if ((apb_side ? apb_irq : i2c_irq) !== level) begin
      errors++;
      $display("%s: interrupt did not reach level %0d within 20 cycles", name, level);
    end
  endtask

  task automatic test_reset_defaults();
    int e0;
    e0 = errors;
    apb_expect("rst apb dev_addr", reg_addr(IDX_DEV_ADDR), 1'b0, 32'h6F);
    apb_expect("rst apb enable", reg_addr(IDX_ENABLE), 1'b0, 32'd0);
    apb_expect("rst apb debounce", reg_addr(IDX_DEBOUNCE), 1'b0, 32'd20);
    apb_expect("rst apb scl_dly", reg_addr(IDX_SCL_DLY), 1'b0, 32'd20);
    apb_expect("rst apb sda_dly", reg_addr(IDX_SDA_DLY), 1'b0, 32'd8);
    i2c_expect("rst i2c dev_addr", IDX_DEV_ADDR, 1'b0, 8'h6F);
    i2c_expect("rst i2c enable", IDX_ENABLE, 1'b0, 8'd0);
    i2c_expect("rst i2c debounce", IDX_DEBOUNCE, 1'b0, 8'd20);
    i2c_expect("rst i2c scl_dly", IDX_SCL_DLY, 1'b0, 8'd20);
    i2c_expect("rst i2c sda_dly", IDX_SDA_DLY, 1'b0, 8'd8);
    check_eq("rst out dev_addr", 32'h6F, dev_addr);
    check_eq("rst out enable", 32'd0, enable);
    check_eq("rst out debounce", 32'd20, debounce);
    check_eq("rst out scl_dly", 32'd20, scl_dly);
    check_eq("rst out sda_dly", 32'd8, sda_dly);
    check_eq("rst i2c_irq", 32'd0, i2c_irq);
    check_eq("rst apb_irq", 32'd0, apb_irq);
    report_test("reset_defaults", e0);
  endtask

  task automatic test_config();
    int        e0;
    reg_byte_t dev;
    reg_byte_t dbn;
    reg_byte_t scl;
    reg_byte_t sda;
    e0 = errors;
    dev = 8'($urandom()) & 8'h7F;
    dbn = 8'($urandom());
    scl = 8'($urandom());
    sda = 8'($urandom());
    apb_write(reg_addr(IDX_DEV_ADDR), apb_data_t'(dev));
    apb_write(reg_addr(IDX_ENABLE), 32'd1);
    apb_write(reg_addr(IDX_DEBOUNCE), apb_data_t'(dbn));
    apb_write(reg_addr(IDX_SCL_DLY), apb_data_t'(scl));
    apb_write(reg_addr(IDX_SDA_DLY), apb_data_t'(sda));
    i2c_expect("cfg i2c dev_addr", IDX_DEV_ADDR, 1'b0, dev);
    i2c_expect("cfg i2c enable", IDX_ENABLE, 1'b0, 8'd1);
    i2c_expect("cfg i2c debounce", IDX_DEBOUNCE, 1'b0, dbn);
    i2c_expect("cfg i2c scl_dly", IDX_SCL_DLY, 1'b0, scl);
    i2c_expect("cfg i2c sda_dly", IDX_SDA_DLY, 1'b0, sda);
    check_eq("cfg out dev_addr", dev, dev_addr);
    check_eq("cfg out enable", 32'd1, enable);
    check_eq("cfg out debounce", dbn, debounce);
    check_eq("cfg out scl_dly", scl, scl_dly);
    check_eq("cfg out sda_dly", sda, sda_dly);
    // upper address bits set, outside the register window
    apb_write(12'h400 | reg_addr(IDX_DEBOUNCE), apb_data_t'(~dbn));
    apb_expect("cfg window write", reg_addr(IDX_DEBOUNCE), 1'b0, apb_data_t'(dbn));
    apb_expect("cfg window read", 12'h400 | reg_addr(IDX_DEBOUNCE), 1'b0, 32'd0);
    report_test("config", e0);
  endtask

  task automatic test_mailboxes();
    int        e0;
    reg_byte_t m_i2a;
    reg_byte_t m_a2i;
    e0 = errors;
    m_i2a = 8'($urandom());
    m_a2i = 8'($urandom());
    i2c_write(IDX_MSG_I2A, m_i2a);
    apb_expect("mbx i2a status set", reg_addr(IDX_MSG_I2A_ST), 1'b0, 32'd1);
    apb_write(reg_addr(IDX_IRQ_APB_EN), 32'd1);
    wait_irq("mbx apb_irq rise", 1'b1, 1'b1);
    apb_expect("mbx i2a data", reg_addr(IDX_MSG_I2A), 1'b1, apb_data_t'(m_i2a));
    wait_irq("mbx apb_irq fall", 1'b1, 1'b0);
    apb_expect("mbx i2a status clr", reg_addr(IDX_MSG_I2A_ST), 1'b0, 32'd0);
    apb_write(reg_addr(IDX_MSG_A2I), apb_data_t'(m_a2i));
    i2c_expect("mbx a2i status set", IDX_MSG_A2I_ST, 1'b0, 8'd1);
    i2c_write(IDX_IRQ_I2C_EN, 8'd1);
    wait_irq("mbx i2c_irq rise", 1'b0, 1'b1);
    i2c_expect("mbx a2i data", IDX_MSG_A2I, 1'b1, m_a2i);
    wait_irq("mbx i2c_irq fall", 1'b0, 1'b0);
    i2c_expect("mbx a2i status clr", IDX_MSG_A2I_ST, 1'b0, 8'd0);
    apb_write(reg_addr(IDX_IRQ_APB_EN), 32'd0);
    i2c_write(IDX_IRQ_I2C_EN, 8'd0);
    report_test("mailboxes", e0);
  endtask

  task automatic test_fifo_i2a();
    int        e0;
    reg_byte_t sent[$];
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      sent.push_back(8'($urandom()));
      i2c_write(IDX_F_I2A_WR, sent[i]);
    end
    apb_expect("i2a flags 5", reg_addr(IDX_F_I2A_FLAGS), 1'b0, apb_data_t'(FLG_LT_HALF));
    foreach (sent[i]) apb_expect("i2a data", reg_addr(IDX_F_I2A_RD), 1'b1, apb_data_t'(sent[i]));
    apb_expect("i2a flags empty", reg_addr(IDX_F_I2A_FLAGS), 1'b0, apb_data_t'(FLG_EMPTY));
    for (int i = 0; i < 3; i++) i2c_write(IDX_F_I2A_WR, 8'($urandom()));
    apb_expect("i2a flags refill", reg_addr(IDX_F_I2A_FLAGS), 1'b0, apb_data_t'(FLG_LT_QTR));
    apb_write(reg_addr(IDX_F_I2A_FLUSH), 32'd1);
    apb_write(reg_addr(IDX_F_I2A_FLUSH), 32'd0);
    apb_expect("i2a flags flushed", reg_addr(IDX_F_I2A_FLAGS), 1'b0, apb_data_t'(FLG_EMPTY));
    report_test("fifo_i2a", e0);
  endtask

  task automatic test_fifo_a2i_irq();
    int        e0;
    reg_byte_t first;
    e0 = errors;
    i2c_write(IDX_IRQ_I2C_SEL_RD, 8'h01 << FLG_FULL);
    i2c_write(IDX_IRQ_I2C_EN, 8'b010);
    first = 8'($urandom());
    apb_write(reg_addr(IDX_F_A2I_WR), apb_data_t'(first));
    for (int i = 1; i < 16; i++) apb_write(reg_addr(IDX_F_A2I_WR), apb_data_t'($urandom()));
    wait_irq("a2i i2c_irq full", 1'b0, 1'b1);
    i2c_expect("a2i irq status", IDX_IRQ_I2C_ST, 1'b0, 8'b010);
    apb_write(reg_addr(IDX_F_A2I_WR), apb_data_t'($urandom()));  // no room, dropped
    i2c_expect("a2i first byte", IDX_F_A2I_RD, 1'b1, first);
    i2c_expect("a2i flags 15", IDX_F_A2I_FLAGS, 1'b0, FLG_ONE_LEFT);
    wait_irq("a2i i2c_irq clear", 1'b0, 1'b0);
    report_test("fifo_a2i_irq", e0);
  endtask

  initial begin
    void'($urandom(32'h54f3));
    clk         = 1'b1;
    apb_waddr   = '0;
    apb_wdata   = '0;
    apb_wr_en   = 1'b0;
    apb_raddr   = '0;
    apb_rd_done = 1'b0;
    i2c_addr    = '0;
    i2c_wdata   = '0;
    i2c_wr_en   = 1'b0;
    i2c_rd_done = 1'b0;
    repeat (10) @(posedge rst);
    clk <= 1'b0;
    test_reset_defaults();
    test_config();
    test_mailboxes();
    test_fifo_i2a();
    test_fifo_a2i_irq();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bridge_regs_top.sv
// apb to i2c register bridge top level with configuration outputs and interrupts
`timescale 1ns/1ps
`default_nettype none

module bridge_regs_top #(
  parameter int                         FIFO_DEPTH   = 16,
  parameter bridge_regs_pkg::dev_addr_t DEF_DEV_ADDR = bridge_regs_pkg::RST_DEV_ADDR,
  parameter bridge_regs_pkg::reg_byte_t DEF_DEBOUNCE = bridge_regs_pkg::RST_DEBOUNCE,
  parameter bridge_regs_pkg::reg_byte_t DEF_SCL_DLY  = bridge_regs_pkg::RST_SCL_DLY,
  parameter bridge_regs_pkg::reg_byte_t DEF_SDA_DLY  = bridge_regs_pkg::RST_SDA_DLY
) (
  input  logic                       rst_i,  // clock
  input  logic                       clk_i,  // async reset, active high
  // apb host
  input  bridge_regs_pkg::apb_addr_t apb_waddr_i,
  input  bridge_regs_pkg::apb_data_t apb_wdata_i,
  input  logic                       apb_wr_en_i,
  input  bridge_regs_pkg::apb_addr_t apb_raddr_i,
  output bridge_regs_pkg::apb_data_t apb_rdata_o,
  input  logic                       apb_rd_done_i,
  // i2c target engine
  input  bridge_regs_pkg::reg_idx_t  i2c_reg_addr_i,
  input  bridge_regs_pkg::reg_byte_t i2c_reg_wdata_i,
  input  logic                       i2c_reg_wr_en_i,
  output bridge_regs_pkg::reg_byte_t i2c_reg_rdata_o,
  input  logic                       i2c_rd_done_i,
  output bridge_regs_pkg::dev_addr_t i2c_dev_addr_o,
  output logic                       i2c_enable_o,
  output bridge_regs_pkg::reg_byte_t i2c_debounce_o,
  output bridge_regs_pkg::reg_byte_t i2c_scl_dly_o,
  output bridge_regs_pkg::reg_byte_t i2c_sda_dly_o,
  output logic                       i2c_irq_o,
  output logic                       apb_irq_o
);

  reg_access_if apb_acc ();
  reg_access_if i2c_acc ();
  reg_view_if   view ();

  reg_access_decode u_decode (
    .waddr_unused_guard_i(apb_waddr_i),
    .apb_waddr_i    (apb_waddr_i),
    .apb_wdata_i    (apb_wdata_i),
    .apb_wr_en_i    (apb_wr_en_i),
    .apb_raddr_i    (apb_raddr_i),
    .apb_rd_done_i  (apb_rd_done_i),
    .i2c_reg_addr_i (i2c_reg_addr_i),
    .i2c_reg_wdata_i(i2c_reg_wdata_i),
    .i2c_reg_wr_en_i(i2c_reg_wr_en_i),
    .i2c_rd_done_i  (i2c_rd_done_i),
    .apb_acc        (apb_acc),
    .i2c_acc        (i2c_acc)
  );

  reg_bank #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .DEF_DEV_ADDR(DEF_DEV_ADDR),
    .DEF_DEBOUNCE(DEF_DEBOUNCE),
    .DEF_SCL_DLY (DEF_SCL_DLY),
    .DEF_SDA_DLY (DEF_SDA_DLY)
  ) u_bank (
    .rst_i  (rst_i),
    .clk_i  (clk_i),
    .apb_acc(apb_acc),
    .i2c_acc(i2c_acc),
    .view   (view)
  );

  readback_irq u_readback (
    .rst_i          (rst_i),
    .clk_i          (clk_i),
    .apb_acc        (apb_acc),
    .i2c_acc        (i2c_acc),
    .view           (view),
    .apb_rdata_o    (apb_rdata_o),
    .i2c_reg_rdata_o(i2c_reg_rdata_o),
    .i2c_irq_o      (i2c_irq_o),
    .apb_irq_o      (apb_irq_o)
  );

  // configuration straight from the register bank
  assign i2c_dev_addr_o = view.dev_addr;
  assign i2c_enable_o   = view.enable;
  assign i2c_debounce_o = view.debounce;
  assign i2c_scl_dly_o  = view.scl_dly;
  assign i2c_sda_dly_o  = view.sda_dly;

endmodule

`default_nettype wire

//--- readback_irq.sv
// registered read muxes for both hosts and the two interrupt status vectors
`timescale 1ns/1ps
`default_nettype none

module readback_irq (
  input  logic                       rst_i,  // clock
  input  logic                       clk_i,  // async reset, active high
  reg_access_if.dst                  apb_acc,
  reg_access_if.dst                  i2c_acc,
  reg_view_if.view                   view,
  output bridge_regs_pkg::apb_data_t apb_rdata_o,
  output bridge_regs_pkg::reg_byte_t i2c_reg_rdata_o,
  output logic                       i2c_irq_o,
  output logic                       apb_irq_o
);
  import bridge_regs_pkg::*;

  irq_vec_t  irq_i2c_st;
  irq_vec_t  irq_apb_st;
  reg_byte_t apb_rdata_q;
  reg_byte_t i2c_rdata_q;

  // fifo term is the mask bit picked by the current flag code
  assign irq_i2c_st = {
    view.irq_i2c_en[2] & view.irq_i2c_sel_wr[view.f_i2a_flags],
    view.irq_i2c_en[1] & view.irq_i2c_sel_rd[view.f_a2i_flags],
    view.irq_i2c_en[0] & view.msg_a2i_st
  };
  assign irq_apb_st = {
    view.irq_apb_en[2] & view.irq_apb_sel_wr[view.f_a2i_flags],
    view.irq_apb_en[1] & view.irq_apb_sel_rd[view.f_i2a_flags],
    view.irq_apb_en[0] & view.msg_i2a_st
  };

  assign i2c_irq_o = |irq_i2c_st;
  assign apb_irq_o = |irq_apb_st;

  // each fifo read port is visible only to its consuming host
  function automatic reg_byte_t rd_mux(input reg_idx_t idx, input logic apb_side);
    reg_byte_t d;
    d = '0;
    case (idx)
      IDX_DEV_ADDR:       d = reg_byte_t'(view.dev_addr);
      IDX_ENABLE:         d = reg_byte_t'(view.enable);
      IDX_DEBOUNCE:       d = view.debounce;
      IDX_SCL_DLY:        d = view.scl_dly;
      IDX_SDA_DLY:        d = view.sda_dly;
      IDX_MSG_I2A:        d = view.msg_i2a;
      IDX_MSG_I2A_ST:     d = reg_byte_t'(view.msg_i2a_st);
      IDX_MSG_A2I:        d = view.msg_a2i;
      IDX_MSG_A2I_ST:     d = reg_byte_t'(view.msg_a2i_st);
      IDX_F_I2A_RD:       d = apb_side ? view.f_i2a_rdata : '0;
      IDX_F_I2A_FLUSH:    d = reg_byte_t'(view.f_i2a_flush);
      IDX_F_I2A_FLAGS:    d = reg_byte_t'(view.f_i2a_flags);
      IDX_F_A2I_RD:       d = apb_side ? '0 : view.f_a2i_rdata;
      IDX_F_A2I_FLUSH:    d = reg_byte_t'(view.f_a2i_flush);
      IDX_F_A2I_FLAGS:    d = reg_byte_t'(view.f_a2i_flags);
      IDX_IRQ_I2C_ST:     d = reg_byte_t'(irq_i2c_st);
      IDX_IRQ_I2C_EN:     d = reg_byte_t'(view.irq_i2c_en);
      IDX_IRQ_I2C_SEL_WR: d = view.irq_i2c_sel_wr;
      IDX_IRQ_I2C_SEL_RD: d = view.irq_i2c_sel_rd;
      IDX_IRQ_APB_ST:     d = reg_byte_t'(irq_apb_st);
      IDX_IRQ_APB_EN:     d = reg_byte_t'(view.irq_apb_en);
      IDX_IRQ_APB_SEL_WR: d = view.irq_apb_sel_wr;
      IDX_IRQ_APB_SEL_RD: d = view.irq_apb_sel_rd;
      default:            d = '0;  // data ports and holes read zero
    endcase
    return d;
  endfunction

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      apb_rdata_q <= '0;
      i2c_rdata_q <= '0;
    end else begin
      apb_rdata_q <= rd_mux(apb_acc.rd_idx, 1'b1);
      i2c_rdata_q <= rd_mux(i2c_acc.rd_idx, 1'b0);
    end
  end

  assign apb_rdata_o     = apb_data_t'(apb_rdata_q);  // zero extended
  assign i2c_reg_rdata_o = i2c_rdata_q;

endmodule

`default_nettype wire

//--- reg_bank.sv
// bridge register storage, mailbox status and fifo push/pop generation
`timescale 1ns/1ps
`default_nettype none

module reg_bank #(
  parameter int                         FIFO_DEPTH   = 16,
  parameter bridge_regs_pkg::dev_addr_t DEF_DEV_ADDR = bridge_regs_pkg::RST_DEV_ADDR,
  parameter bridge_regs_pkg::reg_byte_t DEF_DEBOUNCE = bridge_regs_pkg::RST_DEBOUNCE,
  parameter bridge_regs_pkg::reg_byte_t DEF_SCL_DLY  = bridge_regs_pkg::RST_SCL_DLY,
  parameter bridge_regs_pkg::reg_byte_t DEF_SDA_DLY  = bridge_regs_pkg::RST_SDA_DLY
) (
  input  logic      rst_i,  // clock
  input  logic      clk_i,  // async reset, active high
  reg_access_if.dst apb_acc,
  reg_access_if.dst i2c_acc,
  reg_view_if.bank  view
);
  import bridge_regs_pkg::*;
  import fifo_pkg::*;

  logic      i2a_wr, a2i_wr;          // fifo data port writes
  logic      i2a_msg_wr, a2i_msg_wr;  // mailbox writes
  logic      i2a_push, a2i_push;
  logic      i2a_pop, a2i_pop;
  reg_byte_t i2a_wdata, a2i_wdata;

  assign i2a_wr     = i2c_acc.wr_stb && (i2c_acc.wr_idx == IDX_F_I2A_WR);
  assign a2i_wr     = apb_acc.wr_stb && (apb_acc.wr_idx == IDX_F_A2I_WR);
  assign i2a_msg_wr = i2c_acc.wr_stb && (i2c_acc.wr_idx == IDX_MSG_I2A);
  assign a2i_msg_wr = apb_acc.wr_stb && (apb_acc.wr_idx == IDX_MSG_A2I);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      view.dev_addr       <= DEF_DEV_ADDR;
      view.enable         <= 1'b0;
      view.debounce       <= DEF_DEBOUNCE;
      view.scl_dly        <= DEF_SCL_DLY;
      view.sda_dly        <= DEF_SDA_DLY;
      view.msg_i2a        <= '0;
      view.msg_a2i        <= '0;
      view.msg_i2a_st     <= 1'b0;
      view.msg_a2i_st     <= 1'b0;
      view.f_i2a_flush    <= 1'b0;
      view.f_a2i_flush    <= 1'b0;
      view.irq_i2c_en     <= '0;
      view.irq_i2c_sel_wr <= '0;
      view.irq_i2c_sel_rd <= '0;
      view.irq_apb_en     <= '0;
      view.irq_apb_sel_wr <= '0;
      view.irq_apb_sel_rd <= '0;
      i2a_push <= 1'b0;
      a2i_push <= 1'b0;
      i2a_pop  <= 1'b0;
      a2i_pop  <= 1'b0;
    end else begin
      if (i2c_acc.wr_stb) begin
        case (i2c_acc.wr_idx)
          IDX_MSG_I2A:        view.msg_i2a        <= i2c_acc.wr_data;
          IDX_F_I2A_FLUSH:    view.f_i2a_flush    <= i2c_acc.wr_data[0];
          IDX_F_A2I_FLUSH:    view.f_a2i_flush    <= i2c_acc.wr_data[0];
          IDX_IRQ_I2C_EN:     view.irq_i2c_en     <= i2c_acc.wr_data[2:0];
          IDX_IRQ_I2C_SEL_WR: view.irq_i2c_sel_wr <= i2c_acc.wr_data;
          IDX_IRQ_I2C_SEL_RD: view.irq_i2c_sel_rd <= i2c_acc.wr_data;
          default: ;
        endcase
      end
      // apb comes second so it wins a same-cycle flush write
      if (apb_acc.wr_stb) begin
        case (apb_acc.wr_idx)
          IDX_DEV_ADDR:       view.dev_addr       <= apb_acc.wr_data[6:0];
          IDX_ENABLE:         view.enable         <= apb_acc.wr_data[0];
          IDX_DEBOUNCE:       view.debounce       <= apb_acc.wr_data;
          IDX_SCL_DLY:        view.scl_dly        <= apb_acc.wr_data;
          IDX_SDA_DLY:        view.sda_dly        <= apb_acc.wr_data;
          IDX_MSG_A2I:        view.msg_a2i        <= apb_acc.wr_data;
          IDX_F_I2A_FLUSH:    view.f_i2a_flush    <= apb_acc.wr_data[0];
          IDX_F_A2I_FLUSH:    view.f_a2i_flush    <= apb_acc.wr_data[0];
          IDX_IRQ_APB_EN:     view.irq_apb_en     <= apb_acc.wr_data[2:0];
          IDX_IRQ_APB_SEL_WR: view.irq_apb_sel_wr <= apb_acc.wr_data;
          IDX_IRQ_APB_SEL_RD: view.irq_apb_sel_rd <= apb_acc.wr_data;
          default: ;
        endcase
      end

      // new-message flags, a write beats a same-cycle read-complete
      if (i2a_msg_wr) view.msg_i2a_st <= 1'b1;
      else if (apb_acc.rd_done && apb_acc.rd_idx == IDX_MSG_I2A) view.msg_i2a_st <= 1'b0;
      if (a2i_msg_wr) view.msg_a2i_st <= 1'b1;
      else if (i2c_acc.rd_done && i2c_acc.rd_idx == IDX_MSG_A2I) view.msg_a2i_st <= 1'b0;

      i2a_push <= i2a_wr;
      a2i_push <= a2i_wr;
      i2a_pop  <= apb_acc.rd_done && (apb_acc.rd_idx == IDX_F_I2A_RD);
      a2i_pop  <= i2c_acc.rd_done && (i2c_acc.rd_idx == IDX_F_A2I_RD);
    end
  end

  // staged write data, pushed on the following edge
  always_ff @(posedge rst_i) begin
    if (i2a_wr) i2a_wdata <= i2c_acc.wr_data;
    if (a2i_wr) a2i_wdata <= apb_acc.wr_data;
  end

  byte_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_i2a (
    .rst_i    (rst_i),
    .clk_i    (clk_i),
    .flush_i  (view.f_i2a_flush),
    .push_i   (i2a_push),
    .wr_data_i(i2a_wdata),
    .pop_i    (i2a_pop),
    .rd_data_o(view.f_i2a_rdata),
    .flags_o  (view.f_i2a_flags)
  );

  byte_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_a2i (
    .rst_i    (rst_i),
    .clk_i    (clk_i),
    .flush_i  (view.f_a2i_flush),
    .push_i   (a2i_push),
    .wr_data_i(a2i_wdata),
    .pop_i    (a2i_pop),
    .rd_data_o(view.f_a2i_rdata),
    .flags_o  (view.f_a2i_flags)
  );

  // a push into a full fifo leaves it full
  a_i2a_drop: assert property (@(posedge rst_i) disable iff (clk_i)
    i2a_push && !i2a_pop && !view.f_i2a_flush && view.f_i2a_flags == FLG_FULL
    |=> view.f_i2a_flags == FLG_FULL);
  a_a2i_drop: assert property (@(posedge rst_i) disable iff (clk_i)
    a2i_push && !a2i_pop && !view.f_a2i_flush && view.f_a2i_flags == FLG_FULL
    |=> view.f_a2i_flags == FLG_FULL);

  a_i2a_msg: assert property (@(posedge rst_i) disable iff (clk_i)
    $rose(view.msg_i2a_st) |-> $past(i2a_msg_wr));
  a_a2i_msg: assert property (@(posedge rst_i) disable iff (clk_i)
    $rose(view.msg_a2i_st) |-> $past(a2i_msg_wr));

endmodule

`default_nettype wire

//--- byte_fifo.sv
// synchronous byte fifo with flush and a fill-level flag code
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                       rst_i,   // clock
  input  logic                       clk_i,   // async reset, active high
  input  logic                       flush_i,
  input  logic                       push_i,
  input  bridge_regs_pkg::reg_byte_t wr_data_i,
  input  logic                       pop_i,
  output bridge_regs_pkg::reg_byte_t rd_data_o,
  output fifo_pkg::fifo_flags_t      flags_o
);
  import bridge_regs_pkg::*;
  import fifo_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  reg_byte_t     mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // overflow and underflow are silently dropped
  assign do_push = push_i && !flush_i && (count != CW'(DEPTH));
  assign do_pop  = pop_i && !flush_i && (count != '0);

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin  // held empty while flush is set
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  always_ff @(posedge rst_i) begin
    if (do_push) mem[wr_ptr] <= wr_data_i;
  end

  assign rd_data_o = mem[rd_ptr];  // oldest entry, no read latency

  always_comb begin
    if (count == '0) flags_o = FLG_EMPTY;
    else if (count == CW'(1)) flags_o = FLG_ONE;
    else if (int'(count) < DEPTH / 4) flags_o = FLG_LT_QTR;
    else if (int'(count) < DEPTH / 2) flags_o = FLG_LT_HALF;
    else if (int'(count) < (3 * DEPTH) / 4) flags_o = FLG_LT_3QTR;
    else if (int'(count) < DEPTH - 1) flags_o = FLG_LT_FULL1;
    else if (int'(count) == DEPTH - 1) flags_o = FLG_ONE_LEFT;
    else flags_o = FLG_FULL;
  end

  a_count_max: assert property (@(posedge rst_i) disable iff (clk_i) int'(count) <= DEPTH);

endmodule

`default_nettype wire

//--- reg_access_decode.sv
// maps apb word addresses and i2c register indices onto one byte-index access space
`timescale 1ns/1ps
`default_nettype none

module reg_access_decode (
  input  bridge_regs_pkg::apb_addr_t waddr_unused_guard_i,
  input  bridge_regs_pkg::apb_addr_t apb_waddr_i,
  input  bridge_regs_pkg::apb_data_t apb_wdata_i,
  input  logic                       apb_wr_en_i,
  input  bridge_regs_pkg::apb_addr_t apb_raddr_i,
  input  logic                       apb_rd_done_i,
  input  bridge_regs_pkg::reg_idx_t  i2c_reg_addr_i,
  input  bridge_regs_pkg::reg_byte_t i2c_reg_wdata_i,
  input  logic                       i2c_reg_wr_en_i,
  input  logic                       i2c_rd_done_i,
  reg_access_if.src                  apb_acc,
  reg_access_if.src                  i2c_acc
);
  import bridge_regs_pkg::*;

  localparam reg_idx_t IDX_NONE = 8'hFF;  // decodes to nothing, reads zero

  logic apb_w_in_win;
  logic apb_r_in_win;

  // only the lowest 1 KB of apb space holds registers
  assign apb_w_in_win = (apb_waddr_i[11:10] == 2'b00);
  assign apb_r_in_win = (apb_raddr_i[11:10] == 2'b00);

  assign apb_acc.wr_stb  = apb_wr_en_i && apb_w_in_win;
  assign apb_acc.wr_idx  = apb_waddr_i[9:2];  // word aligned
  assign apb_acc.wr_data = apb_wdata_i[7:0];
  assign apb_acc.rd_idx  = apb_r_in_win ? apb_raddr_i[9:2] : IDX_NONE;
  assign apb_acc.rd_done = apb_rd_done_i;

  // i2c side is already byte indexed
  assign i2c_acc.wr_stb  = i2c_reg_wr_en_i;
  assign i2c_acc.wr_idx  = i2c_reg_addr_i;
  assign i2c_acc.wr_data = i2c_reg_wdata_i;
  assign i2c_acc.rd_idx  = i2c_reg_addr_i;
  assign i2c_acc.rd_done = i2c_rd_done_i;

endmodule

`default_nettype wire

//--- reg_if.sv
// register access strobes and stored register view passed between bridge stages
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;
  import bridge_regs_pkg::*;

  logic      wr_stb;   // write this cycle
  reg_idx_t  wr_idx;
  reg_byte_t wr_data;
  reg_idx_t  rd_idx;   // index being read
  logic      rd_done;  // host consumed the read byte

  modport src (output wr_stb, wr_idx, wr_data, rd_idx, rd_done);
  modport dst (input wr_stb, wr_idx, wr_data, rd_idx, rd_done);
endinterface

interface reg_view_if;
  import bridge_regs_pkg::*;
  import fifo_pkg::*;

  dev_addr_t   dev_addr;
  logic        enable;
  reg_byte_t   debounce, scl_dly, sda_dly;
  reg_byte_t   msg_i2a, msg_a2i;
  logic        msg_i2a_st, msg_a2i_st;
  logic        f_i2a_flush, f_a2i_flush;
  reg_byte_t   f_i2a_rdata, f_a2i_rdata;  // oldest fifo entries
  fifo_flags_t f_i2a_flags, f_a2i_flags;
  irq_vec_t    irq_i2c_en, irq_apb_en;
  reg_byte_t   irq_i2c_sel_wr, irq_i2c_sel_rd;
  reg_byte_t   irq_apb_sel_wr, irq_apb_sel_rd;

  modport bank (
    output dev_addr, enable, debounce, scl_dly, sda_dly, msg_i2a, msg_a2i,
           msg_i2a_st, msg_a2i_st, f_i2a_flush, f_a2i_flush, f_i2a_rdata,
           f_a2i_rdata, f_i2a_flags, f_a2i_flags, irq_i2c_en, irq_apb_en,
           irq_i2c_sel_wr, irq_i2c_sel_rd, irq_apb_sel_wr, irq_apb_sel_rd
  );
  modport view (
    input dev_addr, enable, debounce, scl_dly, sda_dly, msg_i2a, msg_a2i,
          msg_i2a_st, msg_a2i_st, f_i2a_flush, f_a2i_flush, f_i2a_rdata,
          f_a2i_rdata, f_i2a_flags, f_a2i_flags, irq_i2c_en, irq_apb_en,
          irq_i2c_sel_wr, irq_i2c_sel_rd, irq_apb_sel_wr, irq_apb_sel_rd
  );
endinterface

`default_nettype wire

//--- fifo_pkg.sv
// byte fifo fill-level flag code and its named values
`default_nettype none

package fifo_pkg;

  typedef logic [2:0] fifo_flags_t;

  // checked in this order, first match wins
  localparam fifo_flags_t FLG_EMPTY    = 3'd0;
  localparam fifo_flags_t FLG_ONE      = 3'd1;
  localparam fifo_flags_t FLG_LT_QTR   = 3'd2;
  localparam fifo_flags_t FLG_LT_HALF  = 3'd3;
  localparam fifo_flags_t FLG_LT_3QTR  = 3'd4;
  localparam fifo_flags_t FLG_LT_FULL1 = 3'd5;  // below depth minus one
  localparam fifo_flags_t FLG_ONE_LEFT = 3'd6;
  localparam fifo_flags_t FLG_FULL     = 3'd7;

endpackage

`default_nettype wire

//--- bridge_regs_pkg.sv
// bridge register map: field types, register indices and reset defaults
`default_nettype none

package bridge_regs_pkg;

  typedef logic [7:0]  reg_byte_t;  // one register byte
  typedef logic [6:0]  dev_addr_t;  // i2c device address
  typedef logic [7:0]  reg_idx_t;   // register index, apb byte address / 4
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [2:0]  irq_vec_t;   // {fifo wr dir, fifo rd dir, mailbox}

  // reset values of the i2c configuration
  localparam dev_addr_t RST_DEV_ADDR = 7'h6F;
  localparam reg_byte_t RST_DEBOUNCE = 8'd20;
  localparam reg_byte_t RST_SCL_DLY  = 8'd20;
  localparam reg_byte_t RST_SDA_DLY  = 8'd8;

  localparam reg_idx_t IDX_DEV_ADDR = 8'h00;
  localparam reg_idx_t IDX_ENABLE   = 8'h01;
  localparam reg_idx_t IDX_DEBOUNCE = 8'h02;
  localparam reg_idx_t IDX_SCL_DLY  = 8'h03;
  localparam reg_idx_t IDX_SDA_DLY  = 8'h04;

  localparam reg_idx_t IDX_MSG_I2A    = 8'h10;  // mailbox i2c to apb
  localparam reg_idx_t IDX_MSG_I2A_ST = 8'h11;
  localparam reg_idx_t IDX_MSG_A2I    = 8'h12;  // mailbox apb to i2c
  localparam reg_idx_t IDX_MSG_A2I_ST = 8'h13;

  localparam reg_idx_t IDX_F_I2A_WR    = 8'h20;
  localparam reg_idx_t IDX_F_I2A_RD    = 8'h21;
  localparam reg_idx_t IDX_F_I2A_FLUSH = 8'h22;
  localparam reg_idx_t IDX_F_I2A_FLAGS = 8'h23;
  localparam reg_idx_t IDX_F_A2I_WR    = 8'h30;
  localparam reg_idx_t IDX_F_A2I_RD    = 8'h31;
  localparam reg_idx_t IDX_F_A2I_FLUSH = 8'h32;
  localparam reg_idx_t IDX_F_A2I_FLAGS = 8'h33;

  localparam reg_idx_t IDX_IRQ_I2C_ST     = 8'h40;
  localparam reg_idx_t IDX_IRQ_I2C_EN     = 8'h41;
  localparam reg_idx_t IDX_IRQ_I2C_SEL_WR = 8'h42;
  localparam reg_idx_t IDX_IRQ_I2C_SEL_RD = 8'h43;
  localparam reg_idx_t IDX_IRQ_APB_ST     = 8'h50;
  localparam reg_idx_t IDX_IRQ_APB_EN     = 8'h51;
  localparam reg_idx_t IDX_IRQ_APB_SEL_WR = 8'h52;
  localparam reg_idx_t IDX_IRQ_APB_SEL_RD = 8'h53;

endpackage

`default_nettype wire
